//--- rtl/rv_dec_pkg.sv
package rv_dec_pkg;

	localparam int xlen       = 64;
	localparam int reg_addr_w = 5;
	localparam int num_regs   = 32;
	localparam int inst_w     = 32;
	localparam int br_off_w   = 12; // B-type offset bits 12:1

	typedef enum logic [6:0] {
		opc_lui      = 7'b011_0111,
		opc_auipc    = 7'b001_0111,
		opc_jal      = 7'b110_1111,
		opc_jalr     = 7'b110_0111,
		opc_branch   = 7'b110_0011,
		opc_load     = 7'b000_0011,
		opc_store    = 7'b010_0011,
		opc_op_imm   = 7'b001_0011,
		opc_op_imm32 = 7'b001_1011,
		opc_op       = 7'b011_0011,
		opc_op32     = 7'b011_1011
	} opcode_e;

	// passed through untouched to execute
	typedef enum logic [4:0] {
		alu_add  = 5'd0,
		alu_sub  = 5'd1,
		alu_sll  = 5'd2,
		alu_slt  = 5'd3,
		alu_sltu = 5'd4,
		alu_xor  = 5'd5,
		alu_srl  = 5'd6,
		alu_sra  = 5'd7,
		alu_or   = 5'd8,
		alu_and  = 5'd9,
		alu_addw = 5'd10,
		alu_subw = 5'd11,
		alu_sllw = 5'd12,
		alu_srlw = 5'd13,
		alu_sraw = 5'd14
	} alu_op_e;

	typedef enum logic [1:0] {
		src_a_reg  = 2'd0,
		src_a_zero = 2'd1,
		src_a_pc   = 2'd2
	} src_a_sel_e;

	typedef enum logic [1:0] {
		src_b_reg  = 2'd0,
		src_b_imm  = 2'd1,
		src_b_four = 2'd2 // link value for jal/jalr
	} src_b_sel_e;

	typedef enum logic [1:0] {
		fwd_none = 2'd0, // register file
		fwd_ex   = 2'd1,
		fwd_mem  = 2'd2,
		fwd_wb   = 2'd3
	} fwd_sel_e;

endpackage

//--- rtl/dec_bus_if.sv
`timescale 1ns/1ps

interface dec_bus_if;

	logic [rv_dec_pkg::reg_addr_w-1:0] rs1;
	logic [rv_dec_pkg::reg_addr_w-1:0] rs2;
	logic [rv_dec_pkg::reg_addr_w-1:0] rd;
	logic                              uses_rs1;
	logic                              uses_rs2;
	logic [rv_dec_pkg::xlen-1:0]       imm; // sign extended
	rv_dec_pkg::src_a_sel_e            src_a_sel;
	rv_dec_pkg::src_b_sel_e            src_b_sel;
	rv_dec_pkg::alu_op_e               alu_op;
	logic                              reg_wen;
	logic                              mem_wen;
	logic                              wb_sel; // 1 picks load data
	logic                              branch;
	logic                              is_jalr;
	logic [rv_dec_pkg::br_off_w-1:0]   br_offset;

	modport producer (
		output rs1, rs2, rd, uses_rs1, uses_rs2, imm,
		output src_a_sel, src_b_sel, alu_op,
		output reg_wen, mem_wen, wb_sel, branch, is_jalr, br_offset
	);

	modport consumer (
		input rs1, rs2, rd, uses_rs1, uses_rs2, imm,
		input src_a_sel, src_b_sel, alu_op,
		input reg_wen, mem_wen, wb_sel, branch, is_jalr, br_offset
	);

endinterface

//--- rtl/inst_predecode.sv
`timescale 1ns/1ps

module inst_predecode (
	input  logic [rv_dec_pkg::inst_w-1:0] inst,
	dec_bus_if.producer                   bus,
	output logic                          flush_fetch
);

	rv_dec_pkg::opcode_e         opcode;
	logic [2:0]                  funct3;
	logic                        alt; // funct7[5], sub and sra
	logic [rv_dec_pkg::xlen-1:0] i_imm;
	logic [rv_dec_pkg::xlen-1:0] s_imm;
	logic [rv_dec_pkg::xlen-1:0] b_imm;
	logic [rv_dec_pkg::xlen-1:0] u_imm;
	logic [rv_dec_pkg::xlen-1:0] j_imm;

	function automatic rv_dec_pkg::alu_op_e alu_decode(input logic [2:0] f3, input logic sub_ok,
			input logic sra, input logic word);
		rv_dec_pkg::alu_op_e op;
		case (f3)
			3'b000: op = (sub_ok && sra) ? (word ? rv_dec_pkg::alu_subw : rv_dec_pkg::alu_sub)
				: (word ? rv_dec_pkg::alu_addw : rv_dec_pkg::alu_add);
			3'b001: op = word ? rv_dec_pkg::alu_sllw : rv_dec_pkg::alu_sll;
			3'b010: op = rv_dec_pkg::alu_slt;
			3'b011: op = rv_dec_pkg::alu_sltu;
			3'b100: op = rv_dec_pkg::alu_xor;
			3'b101: op = sra ? (word ? rv_dec_pkg::alu_sraw : rv_dec_pkg::alu_sra)
				: (word ? rv_dec_pkg::alu_srlw : rv_dec_pkg::alu_srl);
			3'b110: op = rv_dec_pkg::alu_or;
			default: op = rv_dec_pkg::alu_and;
		endcase
		return op;
	endfunction

	assign opcode = rv_dec_pkg::opcode_e'(inst[6:0]);
	assign funct3 = inst[14:12];
	assign alt    = inst[30];

	assign i_imm = {{(rv_dec_pkg::xlen-12){inst[31]}}, inst[31:20]};
	assign s_imm = {{(rv_dec_pkg::xlen-12){inst[31]}}, inst[31:25], inst[11:7]};
	assign b_imm = {{(rv_dec_pkg::xlen-13){inst[31]}}, inst[31], inst[7], inst[30:25],
		inst[11:8], 1'b0};
	assign u_imm = {{(rv_dec_pkg::xlen-32){inst[31]}}, inst[31:12], 12'b0};
	assign j_imm = {{(rv_dec_pkg::xlen-21){inst[31]}}, inst[31], inst[19:12], inst[20],
		inst[30:21], 1'b0};

	assign bus.rs1       = inst[19:15];
	assign bus.rs2       = inst[24:20];
	assign bus.rd        = inst[11:7];
	assign bus.br_offset = {inst[31], inst[7], inst[30:25], inst[11:8]};

	assign flush_fetch = (opcode == rv_dec_pkg::opc_jalr) || (opcode == rv_dec_pkg::opc_branch);

	always_comb begin
		bus.uses_rs1  = 1'b0;
		bus.uses_rs2  = 1'b0;
		bus.imm       = i_imm;
		bus.src_a_sel = rv_dec_pkg::src_a_reg;
		bus.src_b_sel = rv_dec_pkg::src_b_imm;
		bus.alu_op    = rv_dec_pkg::alu_add;
		bus.reg_wen   = 1'b0;
		bus.mem_wen   = 1'b0;
		bus.wb_sel    = 1'b0;
		bus.branch    = 1'b0;
		bus.is_jalr   = 1'b0;
		case (opcode)
			rv_dec_pkg::opc_lui: begin
				bus.imm       = u_imm;
				bus.src_a_sel = rv_dec_pkg::src_a_zero;
				bus.reg_wen   = 1'b1;
			end
			rv_dec_pkg::opc_auipc: begin
				bus.imm       = u_imm;
				bus.src_a_sel = rv_dec_pkg::src_a_pc;
				bus.reg_wen   = 1'b1;
			end
			rv_dec_pkg::opc_jal: begin
				bus.imm       = j_imm;
				bus.src_a_sel = rv_dec_pkg::src_a_pc;
				bus.src_b_sel = rv_dec_pkg::src_b_four; // link pc+4
				bus.reg_wen   = 1'b1;
			end
			rv_dec_pkg::opc_jalr: begin
				bus.uses_rs1  = 1'b1;
				bus.src_a_sel = rv_dec_pkg::src_a_pc;
				bus.src_b_sel = rv_dec_pkg::src_b_four;
				bus.reg_wen   = 1'b1;
				bus.is_jalr   = 1'b1;
			end
			rv_dec_pkg::opc_branch: begin
				bus.uses_rs1  = 1'b1;
				bus.uses_rs2  = 1'b1;
				bus.imm       = b_imm;
				bus.src_b_sel = rv_dec_pkg::src_b_reg;
				bus.branch    = 1'b1;
				bus.alu_op    = funct3[2] ? (funct3[1] ? rv_dec_pkg::alu_sltu : rv_dec_pkg::alu_slt)
					: rv_dec_pkg::alu_sub;
			end
			rv_dec_pkg::opc_load: begin
				bus.uses_rs1 = 1'b1;
				bus.reg_wen  = 1'b1;
				bus.wb_sel   = 1'b1;
			end
			rv_dec_pkg::opc_store: begin
				bus.uses_rs1 = 1'b1;
				bus.uses_rs2 = 1'b1; // store data
				bus.imm      = s_imm;
				bus.mem_wen  = 1'b1;
			end
			rv_dec_pkg::opc_op_imm, rv_dec_pkg::opc_op_imm32: begin
				bus.uses_rs1 = 1'b1;
				bus.reg_wen  = 1'b1;
				bus.alu_op   = alu_decode(funct3, 1'b0, alt, opcode == rv_dec_pkg::opc_op_imm32);
			end
			rv_dec_pkg::opc_op, rv_dec_pkg::opc_op32: begin
				bus.uses_rs1  = 1'b1;
				bus.uses_rs2  = 1'b1;
				bus.src_b_sel = rv_dec_pkg::src_b_reg;
				bus.reg_wen   = 1'b1;
				bus.alu_op    = alu_decode(funct3, 1'b1, alt, opcode == rv_dec_pkg::opc_op32);
			end
			default: begin
				bus.imm = '0; // unknown opcode, no side effects
			end
		endcase
	end

endmodule

//--- rtl/reg_file.sv
`timescale 1ns/1ps

module reg_file (
	input  logic                              clk,
	input  logic                              reset,
	input  logic [rv_dec_pkg::reg_addr_w-1:0] rs1_addr,
	input  logic [rv_dec_pkg::reg_addr_w-1:0] rs2_addr,
	input  logic                              wr_en,
	input  logic [rv_dec_pkg::reg_addr_w-1:0] wr_addr,
	input  logic [rv_dec_pkg::xlen-1:0]       wr_data,
	output logic [rv_dec_pkg::xlen-1:0]       rs1_data,
	output logic [rv_dec_pkg::xlen-1:0]       rs2_data
);

	logic [rv_dec_pkg::xlen-1:0] regs [rv_dec_pkg::num_regs];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < rv_dec_pkg::num_regs; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en && wr_addr != '0) begin // x0 never written
			regs[wr_addr] <= wr_data;
		end
	end

	// same-cycle writes reach readers through wb forwarding
	assign rs1_data = regs[rs1_addr];
	assign rs2_data = regs[rs2_addr];

	// x0 stays zero as long as the write guard and reset hold
	a_x0_zero: assert property (@(posedge clk) disable iff (reset)
		((rs1_addr == '0) |-> (rs1_data == '0)) and ((rs2_addr == '0) |-> (rs2_data == '0)));

endmodule

//--- rtl/operand_stage.sv
`timescale 1ns/1ps

module operand_stage (
	input  logic                              clk,
	input  logic                              reset,
	input  logic [rv_dec_pkg::xlen-1:0]       pc,
	input  logic                              in_valid,
	dec_bus_if.consumer                       bus,
	input  logic [rv_dec_pkg::reg_addr_w-1:0] ex_rd,
	input  logic                              ex_wen,
	input  logic                              ex_is_load,
	input  logic [rv_dec_pkg::xlen-1:0]       ex_result,
	input  logic [rv_dec_pkg::reg_addr_w-1:0] mem_rd,
	input  logic                              mem_wen,
	input  logic [rv_dec_pkg::xlen-1:0]       mem_data,
	input  logic [rv_dec_pkg::reg_addr_w-1:0] wb_rd,
	input  logic                              wb_wen,
	input  logic [rv_dec_pkg::xlen-1:0]       wb_data,
	input  logic                              out_ready,
	output logic                              in_ready,
	output logic [rv_dec_pkg::xlen-1:0]       jalr_target,
	output logic                              out_valid,
	output logic [rv_dec_pkg::xlen-1:0]       out_pc,
	output logic [rv_dec_pkg::xlen-1:0]       src_a,
	output logic [rv_dec_pkg::xlen-1:0]       src_b,
	output logic [rv_dec_pkg::xlen-1:0]       store_data,
	output logic [rv_dec_pkg::reg_addr_w-1:0] out_rd,
	output logic                              out_reg_wen,
	output logic                              out_mem_wen,
	output logic                              out_wb_sel,
	output rv_dec_pkg::alu_op_e               out_alu_op,
	output logic                              out_branch,
	output logic [rv_dec_pkg::br_off_w-1:0]   out_br_offset
);

	logic [rv_dec_pkg::xlen-1:0] rs1_rf;
	logic [rv_dec_pkg::xlen-1:0] rs2_rf;
	rv_dec_pkg::fwd_sel_e        rs1_sel;
	rv_dec_pkg::fwd_sel_e        rs2_sel;
	logic [rv_dec_pkg::xlen-1:0] rs1_fwd;
	logic [rv_dec_pkg::xlen-1:0] rs2_fwd;
	logic [rv_dec_pkg::xlen-1:0] op_a;
	logic [rv_dec_pkg::xlen-1:0] op_b;
	logic                        load_use;
	logic                        accept;

	// youngest producer wins
	function automatic rv_dec_pkg::fwd_sel_e fwd_pick(input logic [rv_dec_pkg::reg_addr_w-1:0] rs);
		if (rs == '0) begin
			return rv_dec_pkg::fwd_none; // x0 from the register file
		end else if (ex_wen && ex_rd == rs) begin
			return rv_dec_pkg::fwd_ex;
		end else if (mem_wen && mem_rd == rs) begin
			return rv_dec_pkg::fwd_mem;
		end else if (wb_wen && wb_rd == rs) begin
			return rv_dec_pkg::fwd_wb;
		end
		return rv_dec_pkg::fwd_none;
	endfunction

	function automatic logic [rv_dec_pkg::xlen-1:0] fwd_value(input rv_dec_pkg::fwd_sel_e sel,
			input logic [rv_dec_pkg::xlen-1:0] rf);
		case (sel)
			rv_dec_pkg::fwd_ex:  return ex_result;
			rv_dec_pkg::fwd_mem: return mem_data;
			rv_dec_pkg::fwd_wb:  return wb_data;
			default:             return rf;
		endcase
	endfunction

	reg_file u_reg_file (
		.clk      (clk),
		.reset    (reset),
		.rs1_addr (bus.rs1),
		.rs2_addr (bus.rs2),
		.wr_en    (wb_wen),
		.wr_addr  (wb_rd),
		.wr_data  (wb_data),
		.rs1_data (rs1_rf),
		.rs2_data (rs2_rf)
	);

	always_comb begin
		rs1_sel = fwd_pick(bus.rs1);
		rs2_sel = fwd_pick(bus.rs2);
		rs1_fwd = fwd_value(rs1_sel, rs1_rf);
		rs2_fwd = fwd_value(rs2_sel, rs2_rf);
	end

	always_comb begin
		case (bus.src_a_sel)
			rv_dec_pkg::src_a_reg: op_a = rs1_fwd;
			rv_dec_pkg::src_a_pc:  op_a = pc;
			default:               op_a = '0;
		endcase
		case (bus.src_b_sel)
			rv_dec_pkg::src_b_reg:  op_b = rs2_fwd;
			rv_dec_pkg::src_b_imm:  op_b = bus.imm;
			rv_dec_pkg::src_b_four: op_b = rv_dec_pkg::xlen'(4);
			default:                op_b = '0;
		endcase
	end

	assign jalr_target = (rs1_fwd + bus.imm) & ~rv_dec_pkg::xlen'(1);

	// load result not ready until mem
	assign load_use = ex_is_load && ex_wen && ex_rd != '0
		&& ((bus.uses_rs1 && bus.rs1 == ex_rd) || (bus.uses_rs2 && bus.rs2 == ex_rd));
	assign in_ready = out_ready && !load_use;
	assign accept   = in_valid && in_ready;

	always_ff @(posedge clk) begin
		if (reset) begin
			out_valid   <= 1'b0;
			out_reg_wen <= 1'b0;
			out_mem_wen <= 1'b0;
			out_branch  <= 1'b0;
		end else if (out_ready) begin // bubble on stall or idle
			out_valid   <= accept;
			out_reg_wen <= accept && bus.reg_wen;
			out_mem_wen <= accept && bus.mem_wen;
			out_branch  <= accept && bus.branch;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			out_pc        <= pc;
			src_a         <= op_a;
			src_b         <= op_b;
			store_data    <= rs2_fwd;
			out_rd        <= bus.rd;
			out_wb_sel    <= bus.wb_sel;
			out_alu_op    <= bus.alu_op;
			out_br_offset <= bus.br_offset;
		end
	end

	// x0 targets are dropped by reg_file so a write only needs a live slot
	a_wen_valid: assert property (@(posedge clk) disable iff (reset)
		out_reg_wen |-> (out_valid && !out_mem_wen));

	a_hold: assert property (@(posedge clk) disable iff (reset)
		!out_ready |=> $stable({out_valid, out_pc, src_a, src_b, store_data, out_rd,
			out_reg_wen, out_mem_wen, out_wb_sel, out_alu_op, out_branch, out_br_offset}));

endmodule

//--- rtl/decode_top.sv
`timescale 1ns/1ps

module decode_top (
	input  logic                              clk,
	input  logic                              reset,
	input  logic                              in_valid,
	input  logic [rv_dec_pkg::inst_w-1:0]     inst,
	input  logic [rv_dec_pkg::xlen-1:0]       pc,
	input  logic                              out_ready,
	input  logic [rv_dec_pkg::reg_addr_w-1:0] ex_rd,
	input  logic                              ex_wen,
	input  logic                              ex_is_load,
	input  logic [rv_dec_pkg::xlen-1:0]       ex_result,
	input  logic [rv_dec_pkg::reg_addr_w-1:0] mem_rd,
	input  logic                              mem_wen,
	input  logic [rv_dec_pkg::xlen-1:0]       mem_data,
	input  logic [rv_dec_pkg::reg_addr_w-1:0] wb_rd,
	input  logic                              wb_wen,
	input  logic [rv_dec_pkg::xlen-1:0]       wb_data,
	output logic                              in_ready,
	output logic                              flush_fetch,
	output logic [rv_dec_pkg::xlen-1:0]       jalr_target,
	output logic                              out_valid,
	output logic [rv_dec_pkg::xlen-1:0]       out_pc,
	output logic [rv_dec_pkg::xlen-1:0]       src_a,
	output logic [rv_dec_pkg::xlen-1:0]       src_b,
	output logic [rv_dec_pkg::xlen-1:0]       store_data,
	output logic [rv_dec_pkg::reg_addr_w-1:0] out_rd,
	output logic                              out_reg_wen,
	output logic                              out_mem_wen,
	output logic                              out_wb_sel,
	output rv_dec_pkg::alu_op_e               out_alu_op,
	output logic                              out_branch,
	output logic [rv_dec_pkg::br_off_w-1:0]   out_br_offset
);

	dec_bus_if dec_bus ();

	inst_predecode u_predecode (
		.inst        (inst),
		.bus         (dec_bus.producer),
		.flush_fetch (flush_fetch)
	);

	operand_stage u_operand (
		.clk           (clk),
		.reset         (reset),
		.pc            (pc),
		.in_valid      (in_valid),
		.bus           (dec_bus.consumer),
		.ex_rd         (ex_rd),
		.ex_wen        (ex_wen),
		.ex_is_load    (ex_is_load),
		.ex_result     (ex_result),
		.mem_rd        (mem_rd),
		.mem_wen       (mem_wen),
		.mem_data      (mem_data),
		.wb_rd         (wb_rd),
		.wb_wen        (wb_wen),
		.wb_data       (wb_data),
		.out_ready     (out_ready),
		.in_ready      (in_ready),
		.jalr_target   (jalr_target),
		.out_valid     (out_valid),
		.out_pc        (out_pc),
		.src_a         (src_a),
		.src_b         (src_b),
		.store_data    (store_data),
		.out_rd        (out_rd),
		.out_reg_wen   (out_reg_wen),
		.out_mem_wen   (out_mem_wen),
		.out_wb_sel    (out_wb_sel),
		.out_alu_op    (out_alu_op),
		.out_branch    (out_branch),
		.out_br_offset (out_br_offset)
	);

endmodule

//--- dv/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
	output logic clk,
	output logic reset
);

	localparam int half_period  = 10; // 20 ns clock
	localparam int reset_cycles = 8;

	initial begin
		clk = 1'b0;
		forever #(half_period) clk = ~clk;
	end

	initial begin
		reset = 1'b1;
		repeat (reset_cycles) @(posedge clk);
		reset <= 1'b0;
	end

endmodule

//--- dv/decode_tb.sv
`timescale 1ns/1ps

module decode_tb;

	// one table row applied for one clock
	typedef struct packed {
		logic        valid;
		logic [31:0] inst;
		logic [63:0] pc;
		logic [4:0]  ex_rd;
		logic        ex_wen;
		logic        ex_ld;
		logic [63:0] ex_res;
		logic [4:0]  mem_rd;
		logic        mem_wen;
		logic [63:0] mem_dat;
		logic [4:0]  wb_rd;
		logic        wb_wen;
		logic [63:0] wb_dat;
		logic        rdy;
		logic        exp_in_ready;
		logic        exp_flush;
		logic        chk_jalr;
		logic [63:0] exp_jalr;
		logic        exp_valid; // registered side seen one clock later
		logic [63:0] exp_pc;
		logic [63:0] exp_a;
		logic [63:0] exp_b;
		logic [63:0] exp_store;
		logic [4:0]  exp_rd;
		logic        exp_reg_wen;
		logic        exp_mem_wen;
		logic        exp_wb_sel;
		logic [4:0]  exp_alu;
		logic        exp_branch;
		logic [11:0] exp_br;
	} step_t;

	logic                      clk;
	logic                      reset;
	logic                      in_valid;
	logic [31:0]               inst;
	logic [63:0]               pc;
	logic                      out_ready;
	logic [4:0]                ex_rd;
	logic                      ex_wen;
	logic                      ex_is_load;
	logic [63:0]               ex_result;
	logic [4:0]                mem_rd;
	logic                      mem_wen;
	logic [63:0]               mem_data;
	logic [4:0]                wb_rd;
	logic                      wb_wen;
	logic [63:0]               wb_data;
	logic                      in_ready;
	logic                      flush_fetch;
	logic [63:0]               jalr_target;
	logic                      out_valid;
	logic [63:0]               out_pc;
	logic [63:0]               src_a;
	logic [63:0]               src_b;
	logic [63:0]               store_data;
	logic [4:0]                out_rd;
	logic                      out_reg_wen;
	logic                      out_mem_wen;
	logic                      out_wb_sel;
	rv_dec_pkg::alu_op_e       out_alu_op;
	logic                      out_branch;
	logic [11:0]               out_br_offset;

	step_t       steps [$];
	string       names [$];
	step_t       cur;
	step_t       idle;
	logic [63:0] model_regs [32];
	logic [63:0] d [8];
	logic [63:0] rnd;
	int          errors;
	int          cycles;
	int          limit;

	tb_clock u_clock (
		.clk   (clk),
		.reset (reset)
	);

	decode_top u_dut (
		.clk           (clk),
		.reset         (reset),
		.in_valid      (in_valid),
		.inst          (inst),
		.pc            (pc),
		.out_ready     (out_ready),
		.ex_rd         (ex_rd),
		.ex_wen        (ex_wen),
		.ex_is_load    (ex_is_load),
		.ex_result     (ex_result),
		.mem_rd        (mem_rd),
		.mem_wen       (mem_wen),
		.mem_data      (mem_data),
		.wb_rd         (wb_rd),
		.wb_wen        (wb_wen),
		.wb_data       (wb_data),
		.in_ready      (in_ready),
		.flush_fetch   (flush_fetch),
		.jalr_target   (jalr_target),
		.out_valid     (out_valid),
		.out_pc        (out_pc),
		.src_a         (src_a),
		.src_b         (src_b),
		.store_data    (store_data),
		.out_rd        (out_rd),
		.out_reg_wen   (out_reg_wen),
		.out_mem_wen   (out_mem_wen),
		.out_wb_sel    (out_wb_sel),
		.out_alu_op    (out_alu_op),
		.out_branch    (out_branch),
		.out_br_offset (out_br_offset)
	);

	function automatic logic [63:0] xorshift(input logic [63:0] x);
		logic [63:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 7);
		y = y ^ (y << 17);
		return y;
	endfunction

	function automatic logic [31:0] add_inst(input logic [4:0] rd, rs1, rs2);
		return {7'b0, rs2, rs1, 3'b000, rd, rv_dec_pkg::opc_op};
	endfunction

	function automatic logic [31:0] itype_inst(input logic [6:0] opc, input logic [4:0] rd, rs1,
			input logic [11:0] imm);
		return {imm, rs1, 3'b000, rd, opc};
	endfunction

	function automatic logic [31:0] store_inst(input logic [4:0] rs1, rs2, input logic [11:0] imm);
		return {imm[11:5], rs2, rs1, 3'b011, imm[4:0], rv_dec_pkg::opc_store}; // sd
	endfunction

	function automatic logic [31:0] branch_inst(input logic [4:0] rs1, rs2, input logic [12:0] off);
		return {off[12], off[10:5], rs2, rs1, 3'b000, off[4:1], off[11], rv_dec_pkg::opc_branch};
	endfunction

	function automatic logic [31:0] upper_inst(input logic [6:0] opc, input logic [4:0] rd,
			input logic [19:0] imm);
		return {imm, rd, opc};
	endfunction

	function automatic logic [31:0] jal_inst(input logic [4:0] rd, input logic [20:0] off);
		return {off[20], off[10:1], off[11], off[19:12], rd, rv_dec_pkg::opc_jal};
	endfunction

	// x0, then ex, mem, wb, then the register array
	function automatic logic [63:0] model_read(input logic [4:0] rs);
		if (rs == 5'd0) return '0;
		if (cur.ex_wen && cur.ex_rd == rs) return cur.ex_res;
		if (cur.mem_wen && cur.mem_rd == rs) return cur.mem_dat;
		if (cur.wb_wen && cur.wb_rd == rs) return cur.wb_dat;
		return model_regs[rs];
	endfunction

	task automatic new_step(input logic valid, input logic [31:0] instr, input logic [63:0] at);
		cur       = '0;
		cur.valid = valid;
		cur.inst  = instr;
		cur.pc    = at;
		cur.rdy   = 1'b1;
	endtask

	// ctl is {flush, reg_wen, mem_wen, branch}
	task automatic add_step(input string name, input logic in_rdy, input logic [3:0] ctl,
			input logic [63:0] a, input logic [63:0] b);
		step_t s;
		step_t prev;
		s              = cur;
		s.exp_in_ready = in_rdy;
		s.exp_flush    = ctl[3];
		s.chk_jalr     = ctl[3] && !ctl[0];
		if (!s.rdy && steps.size() > 0) begin // stage holds its outputs
			prev          = steps[steps.size()-1];
			s.exp_valid   = prev.exp_valid;
			s.exp_pc      = prev.exp_pc;
			s.exp_a       = prev.exp_a;
			s.exp_b       = prev.exp_b;
			s.exp_store   = prev.exp_store;
			s.exp_rd      = prev.exp_rd;
			s.exp_reg_wen = prev.exp_reg_wen;
			s.exp_mem_wen = prev.exp_mem_wen;
			s.exp_wb_sel  = prev.exp_wb_sel;
			s.exp_alu     = prev.exp_alu;
			s.exp_branch  = prev.exp_branch;
			s.exp_br      = prev.exp_br;
		end else begin
			s.exp_valid   = s.valid && in_rdy;
			s.exp_pc      = s.pc;
			s.exp_a       = a;
			s.exp_b       = b;
			s.exp_store   = model_read(s.inst[24:20]); // forwarded rs2
			s.exp_rd      = s.inst[11:7];
			s.exp_reg_wen = s.exp_valid && ctl[2];
			s.exp_mem_wen = s.exp_valid && ctl[1];
			s.exp_branch  = s.exp_valid && ctl[0];
		end
		steps.push_back(s);
		names.push_back(name);
		if (s.wb_wen && s.wb_rd != 5'd0) model_regs[s.wb_rd] = s.wb_dat;
	endtask

	task automatic apply_step(input step_t s);
		in_valid   <= s.valid;
		inst       <= s.inst;
		pc         <= s.pc;
		out_ready  <= s.rdy;
		ex_rd      <= s.ex_rd;
		ex_wen     <= s.ex_wen;
		ex_is_load <= s.ex_ld;
		ex_result  <= s.ex_res;
		mem_rd     <= s.mem_rd;
		mem_wen    <= s.mem_wen;
		mem_data   <= s.mem_dat;
		wb_rd      <= s.wb_rd;
		wb_wen     <= s.wb_wen;
		wb_data    <= s.wb_dat;
	endtask

	task automatic compare(input string name, input string what, input logic [63:0] exp,
			input logic [63:0] act);
		if (exp !== act) begin
			errors++;
			$display("FAILED %s %s: expected %h, actual %h", name, what, exp, act);
		end
	endtask

	task automatic check_quiet(input string name);
		compare(name, "out_valid", 64'(1'b0), 64'(out_valid));
		compare(name, "out_reg_wen", 64'(1'b0), 64'(out_reg_wen));
		compare(name, "out_mem_wen", 64'(1'b0), 64'(out_mem_wen));
		compare(name, "out_branch", 64'(1'b0), 64'(out_branch));
	endtask

	task automatic check_outputs(input int j);
		step_t s;
		s = steps[j];
		compare(names[j], "out_valid", 64'(s.exp_valid), 64'(out_valid));
		compare(names[j], "out_reg_wen", 64'(s.exp_reg_wen), 64'(out_reg_wen));
		compare(names[j], "out_mem_wen", 64'(s.exp_mem_wen), 64'(out_mem_wen));
		compare(names[j], "out_branch", 64'(s.exp_branch), 64'(out_branch));
		if (s.exp_valid) begin
			compare(names[j], "out_pc", s.exp_pc, out_pc);
			compare(names[j], "src_a", s.exp_a, src_a);
			compare(names[j], "src_b", s.exp_b, src_b);
			compare(names[j], "store_data", s.exp_store, store_data);
			compare(names[j], "out_rd", 64'(s.exp_rd), 64'(out_rd));
			compare(names[j], "out_wb_sel", 64'(s.exp_wb_sel), 64'(out_wb_sel));
			compare(names[j], "out_alu_op", 64'(s.exp_alu), 64'(out_alu_op));
		end
		if (s.exp_branch) begin
			compare(names[j], "out_br_offset", 64'(s.exp_br), 64'(out_br_offset));
		end
	endtask

	always @(posedge clk) begin
		cycles++;
		if (limit > 0 && cycles >= limit) begin
			$display("timeout after %0d cycles, the run did not finish", cycles);
			$display("Some tests failed");
			$finish;
		end
	end

	initial begin
		errors = 0;
		cycles = 0;
		limit  = 0;
		idle   = '0;
		idle.rdy = 1'b1;
		apply_step(idle);
		rnd = 64'd36351;
		for (int k = 0; k < 8; k++) begin
			rnd  = xorshift(rnd);
			d[k] = rnd;
		end
		for (int r = 0; r < 32; r++) begin
			model_regs[r] = '0;
		end

		new_step(1'b0, '0, '0);
		cur.wb_wen = 1'b1;
		cur.wb_rd  = 5'd5;
		cur.wb_dat = d[0];
		add_step("wb_write_x5", 1'b1, 4'b0000, '0, '0);
		cur.wb_rd  = 5'd6;
		cur.wb_dat = d[1];
		add_step("wb_write_x6", 1'b1, 4'b0000, '0, '0);
		new_step(1'b1, add_inst(5'd7, 5'd5, 5'd6), 64'h100);
		add_step("op_reads_rf", 1'b1, 4'b0100, model_read(5'd5), model_read(5'd6));
		new_step(1'b1, itype_inst(rv_dec_pkg::opc_op_imm, 5'd8, 5'd5, 12'hFFD), 64'h104);
		add_step("op_imm_i_imm", 1'b1, 4'b0100, model_read(5'd5), 64'hFFFF_FFFF_FFFF_FFFD);
		new_step(1'b1, add_inst(5'd9, 5'd0, 5'd5), 64'h108);
		cur.wb_wen = 1'b1; // x0 writes must not stick
		cur.wb_dat = d[2];
		cur.ex_wen = 1'b1;
		cur.ex_res = d[3];
		add_step("x0_reads_zero", 1'b1, 4'b0100, model_read(5'd0), model_read(5'd5));
		new_step(1'b1, store_inst(5'd5, 5'd6, 12'hFF0), 64'h10C);
		add_step("store_s_imm", 1'b1, 4'b0010, model_read(5'd5), 64'hFFFF_FFFF_FFFF_FFF0);
		new_step(1'b1, upper_inst(rv_dec_pkg::opc_lui, 5'd10, 20'h80001), 64'h110);
		add_step("lui_u_imm", 1'b1, 4'b0100, '0, 64'hFFFF_FFFF_8000_1000);
		new_step(1'b1, upper_inst(rv_dec_pkg::opc_auipc, 5'd11, 20'h12345), 64'h1000);
		add_step("auipc_pc_imm", 1'b1, 4'b0100, cur.pc, 64'h0000_0000_1234_5000);
		new_step(1'b1, jal_inst(5'd1, 21'h800), 64'h2000);
		add_step("jal_pc_four", 1'b1, 4'b0100, cur.pc, 64'd4);

		new_step(1'b1, add_inst(5'd12, 5'd13, 5'd13), 64'h200);
		cur.ex_wen  = 1'b1;
		cur.ex_rd   = 5'd13;
		cur.ex_res  = d[2];
		cur.mem_wen = 1'b1;
		cur.mem_rd  = 5'd13;
		cur.mem_dat = d[3];
		cur.wb_wen  = 1'b1;
		cur.wb_rd   = 5'd13;
		cur.wb_dat  = d[4];
		add_step("fwd_ex_first", 1'b1, 4'b0100, model_read(5'd13), model_read(5'd13));
		cur.ex_wen = 1'b0;
		add_step("fwd_mem_second", 1'b1, 4'b0100, model_read(5'd13), model_read(5'd13));
		cur.mem_wen = 1'b0;
		add_step("fwd_wb_third", 1'b1, 4'b0100, model_read(5'd13), model_read(5'd13));
		cur.wb_wen = 1'b0; // value now lives in the register file
		add_step("fwd_rf_last", 1'b1, 4'b0100, model_read(5'd13), model_read(5'd13));

		new_step(1'b1, add_inst(5'd14, 5'd5, 5'd15), 64'h300);
		cur.ex_wen = 1'b1;
		cur.ex_ld  = 1'b1;
		cur.ex_rd  = 5'd15;
		cur.ex_res = d[5];
		add_step("load_use_stall", 1'b0, 4'b0100, '0, '0);
		cur.ex_wen  = 1'b0;
		cur.ex_ld   = 1'b0;
		cur.mem_wen = 1'b1; // load moved on to mem
		cur.mem_rd  = 5'd15;
		cur.mem_dat = d[5];
		add_step("load_use_accept", 1'b1, 4'b0100, model_read(5'd5), model_read(5'd15));
		new_step(1'b1, add_inst(5'd16, 5'd0, 5'd5), 64'h304);
		cur.ex_wen = 1'b1;
		cur.ex_ld  = 1'b1;
		add_step("load_x0_no_stall", 1'b1, 4'b0100, '0, model_read(5'd5));
		new_step(1'b1, itype_inst(rv_dec_pkg::opc_load, 5'd18, 5'd5, 12'd8), 64'h308);
		cur.exp_wb_sel = 1'b1; // result comes from memory
		add_step("load_wb_sel", 1'b1, 4'b0100, model_read(5'd5), 64'd8);

		new_step(1'b1, itype_inst(rv_dec_pkg::opc_jalr, 5'd1, 5'd6, 12'd13), 64'h400);
		cur.ex_wen   = 1'b1;
		cur.ex_rd    = 5'd6;
		cur.ex_res   = d[6];
		cur.exp_jalr = (model_read(5'd6) + 64'd13) & ~64'd1;
		add_step("jalr_target", 1'b1, 4'b1100, cur.pc, 64'd4);
		new_step(1'b1, branch_inst(5'd5, 5'd6, 13'h1FF8), 64'h404);
		cur.exp_br  = 12'hFFC; // offset -8 as bits 12:1
		cur.exp_alu = rv_dec_pkg::alu_sub; // beq compares by subtraction
		add_step("branch_flush", 1'b1, 4'b1001, model_read(5'd5), model_read(5'd6));

		new_step(1'b1, add_inst(5'd17, 5'd5, 5'd6), 64'h500);
		cur.rdy = 1'b0;
		add_step("backpressure_hold", 1'b0, 4'b0100, '0, '0);
		add_step("backpressure_hold2", 1'b0, 4'b0100, '0, '0);
		cur.rdy = 1'b1;
		add_step("backpressure_release", 1'b1, 4'b0100, model_read(5'd5), model_read(5'd6));
		new_step(1'b0, '0, '0);
		add_step("idle_drain", 1'b1, 4'b0000, '0, '0);

		limit = steps.size() * 4 + 50;

		repeat (3) @(negedge clk);
		check_quiet("in_reset");
		while (reset) @(negedge clk);
		check_quiet("after_reset");

		for (int i = 0; i < steps.size(); i++) begin
			@(posedge clk);
			apply_step(steps[i]);
			@(negedge clk);
			compare(names[i], "in_ready", 64'(steps[i].exp_in_ready), 64'(in_ready));
			compare(names[i], "flush_fetch", 64'(steps[i].exp_flush), 64'(flush_fetch));
			if (steps[i].chk_jalr) begin
				compare(names[i], "jalr_target", steps[i].exp_jalr, jalr_target);
			end
			if (i > 0) begin
				check_outputs(i - 1);
			end
		end
		@(posedge clk);
		apply_step(idle);
		@(negedge clk);
		check_outputs(steps.size() - 1);

		$display("%0d steps run, %0d errors", steps.size(), errors);
		if (errors == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

//--- filelist.f
rtl/rv_dec_pkg.sv
rtl/dec_bus_if.sv
rtl/inst_predecode.sv
rtl/reg_file.sv
rtl/operand_stage.sv
rtl/decode_top.sv
dv/tb_clock.sv
dv/decode_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the decode stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f filelist.f --top-module decode_tb -o decode_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/decode_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "All tests passed" "$log"; then
	exit 0
fi
echo "pass message not found in $log"
exit 1
